// ==== Bender.yml ====
package:
  name: lsu

sources:
  - files:
      - common/core_pkg.sv
      - common/lsu_pkg.sv
      - common/lsu_issue_if.sv
      - rtl/load_store_issue/shift_queue.sv
      - rtl/load_store_issue/load_store_issue.sv
      - rtl/address_gen.sv
      - rtl/store_buffer.sv
      - rtl/lsu_top.sv
  - target: test
    files:
      - tb/tb_lsu.sv

// ==== common/core_pkg.sv ====
package core_pkg;

    // Data and address width of the core.
    parameter int xlen = 32;

    // Reorder-buffer tag width for 32 tags in flight.
    parameter int rob_id_w = 5;

    typedef logic [rob_id_w-1:0] rob_id_t;
    typedef logic [xlen-1:0] word_t;

endpackage

// ==== common/lsu_issue_if.sv ====
`timescale 1ns/1ns

interface lsu_issue_if
    import core_pkg::*, lsu_pkg::*;
();

    logic    valid;
    mem_op_e op;
    rob_id_t rob_id;
    word_t   base;
    offset_t offset;
    word_t   st_data;

    modport src (
        output valid, op, rob_id, base, offset, st_data
    );

    modport dst (
        input valid, op, rob_id, base, offset, st_data
    );

endinterface

// ==== common/lsu_pkg.sv ====
package lsu_pkg;

    import core_pkg::*;

    // Immediate offset width of a memory operation.
    localparam int offset_w = 12;

    typedef logic [offset_w-1:0] offset_t;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    // One entry of the load/store queue.
    typedef struct packed {
        mem_op_e op;
        rob_id_t rob_id;
        rob_id_t base_tag;
        logic    base_ready;
        word_t   base;
        rob_id_t data_tag;
        logic    data_ready;
        word_t   st_data;
        offset_t offset;
    } lsq_entry_t;

    // Operation as it leaves the issue stage.
    typedef struct packed {
        mem_op_e op;
        rob_id_t rob_id;
        word_t   base;
        offset_t offset;
        word_t   st_data;
    } issued_op_t;

endpackage

// ==== rtl/address_gen.sv ====
`timescale 1ns/1ns

module address_gen
    import core_pkg::*, lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    lsu_issue_if.dst issue,

    output logic     mem_rd_valid,
    output word_t    mem_rd_addr,
    output rob_id_t  mem_rd_rob_id,

    output logic     st_wr_valid,
    output word_t    st_wr_addr,
    output word_t    st_wr_data
);

    word_t offset_ext;
    word_t addr;
    word_t addr_q;

    assign offset_ext = {{(xlen - offset_w){issue.offset[offset_w-1]}}, issue.offset};
    assign addr       = issue.base + offset_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rd_valid <= 1'b0;
            st_wr_valid  <= 1'b0;
        end else begin
            mem_rd_valid <= issue.valid && (issue.op == op_load);
            st_wr_valid  <= issue.valid && (issue.op == op_store);
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            addr_q        <= addr;
            mem_rd_rob_id <= issue.rob_id;
            st_wr_data    <= issue.st_data;
        end
    end

    // Both ports share one address register.
    assign mem_rd_addr = addr_q;
    assign st_wr_addr  = addr_q;

endmodule

// ==== rtl/load_store_issue/load_store_issue.sv ====
`timescale 1ns/1ns

module load_store_issue
    import core_pkg::*, lsu_pkg::*;
#(
    parameter int lsq_depth = 8
) (
    input  logic         clk,
    input  logic         rst_n,

    input  logic         disp_valid,
    input  mem_op_e      disp_op,
    input  rob_id_t      disp_rob_id,
    input  logic         disp_base_ready,
    input  rob_id_t      disp_base_tag,
    input  word_t        disp_base,
    input  offset_t      disp_offset,
    input  logic         disp_data_ready,
    input  rob_id_t      disp_data_tag,
    input  word_t        disp_st_data,

    input  logic         cdb_valid,
    input  rob_id_t      cdb_rob_id,
    input  word_t        cdb_data,

    input  logic         st_hold,

    lsu_issue_if.src     issue,
    output logic         lsq_full
);

    lsq_entry_t [lsq_depth-1:0] entries;
    lsq_entry_t [lsq_depth-1:0] wr_data;
    logic       [lsq_depth-1:0] entry_valid;
    logic       [lsq_depth-1:0] wr_en;
    logic       [lsq_depth-1:0] base_hit;
    logic       [lsq_depth-1:0] data_hit;
    logic       [lsq_depth-1:0] store_below;
    logic       [lsq_depth-1:0] ready;
    logic       [lsq_depth-1:0] sel_onehot;
    lsq_entry_t                 enq_entry;
    lsq_entry_t                 sel_entry;
    issued_op_t                 issue_q;
    logic                       issue_valid_q;

    // A broadcast in the dispatch cycle is captured on the way in.
    always_comb begin
        enq_entry.op         = disp_op;
        enq_entry.rob_id     = disp_rob_id;
        enq_entry.base_tag   = disp_base_tag;
        enq_entry.base_ready = disp_base_ready;
        enq_entry.base       = disp_base;
        enq_entry.data_tag   = disp_data_tag;
        enq_entry.data_ready = disp_data_ready;
        enq_entry.st_data    = disp_st_data;
        enq_entry.offset     = disp_offset;
        if (cdb_valid && !disp_base_ready && (disp_base_tag == cdb_rob_id)) begin
            enq_entry.base_ready = 1'b1;
            enq_entry.base       = cdb_data;
        end
        if (cdb_valid && !disp_data_ready && (disp_data_tag == cdb_rob_id)) begin
            enq_entry.data_ready = 1'b1;
            enq_entry.st_data    = cdb_data;
        end
    end

    // Tag match against every waiting operand.
    always_comb begin
        for (int i = 0; i < lsq_depth; i++) begin
            base_hit[i] = cdb_valid && !entries[i].base_ready
                          && (entries[i].base_tag == cdb_rob_id);
            data_hit[i] = cdb_valid && !entries[i].data_ready
                          && (entries[i].data_tag == cdb_rob_id);
            wr_en[i]    = entry_valid[i] && (base_hit[i] || data_hit[i]);
            wr_data[i]  = entries[i];
            if (base_hit[i]) begin
                wr_data[i].base_ready = 1'b1;
                wr_data[i].base       = cdb_data;
            end
            if (data_hit[i]) begin
                wr_data[i].data_ready = 1'b1;
                wr_data[i].st_data    = cdb_data;
            end
        end
    end

    // Stores leave in program order.
    always_comb begin
        store_below[0] = 1'b0;
        for (int i = 1; i < lsq_depth; i++) begin
            store_below[i] = store_below[i-1]
                             | (entry_valid[i-1] && (entries[i-1].op == op_store));
        end
    end

    always_comb begin
        for (int i = 0; i < lsq_depth; i++) begin
            ready[i] = entry_valid[i] && entries[i].base_ready
                       && ((entries[i].op == op_load)
                           || (entries[i].data_ready && !store_below[i] && !st_hold));
        end
    end

    // Lowest set bit is the oldest ready entry.
    assign sel_onehot = ready & (~ready + 1'b1);

    always_comb begin
        sel_entry = entries[0];
        for (int i = 0; i < lsq_depth; i++) begin
            if (sel_onehot[i]) begin
                sel_entry = entries[i];
            end
        end
    end

    shift_queue #(
        .lsq_depth(lsq_depth)
    ) lsq (
        .clk(clk),
        .rst_n(rst_n),
        .enq_valid(disp_valid),
        .enq_data(enq_entry),
        .deq_sel_onehot(sel_onehot),
        .wr_en(wr_en),
        .wr_data(wr_data),
        .entry_douts(entries),
        .entry_valid(entry_valid),
        .full(lsq_full)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= |sel_onehot;
        end
    end

    always_ff @(posedge clk) begin
        if (|sel_onehot) begin
            issue_q.op      <= sel_entry.op;
            issue_q.rob_id  <= sel_entry.rob_id;
            issue_q.base    <= sel_entry.base;
            issue_q.offset  <= sel_entry.offset;
            issue_q.st_data <= sel_entry.st_data;
        end
    end

    assign issue.valid   = issue_valid_q;
    assign issue.op      = issue_q.op;
    assign issue.rob_id  = issue_q.rob_id;
    assign issue.base    = issue_q.base;
    assign issue.offset  = issue_q.offset;
    assign issue.st_data = issue_q.st_data;

endmodule

// ==== rtl/load_store_issue/shift_queue.sv ====
`timescale 1ns/1ns

module shift_queue
    import lsu_pkg::*;
#(
    parameter int lsq_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         enq_valid,
    input  lsq_entry_t                   enq_data,

    input  logic       [lsq_depth-1:0]   deq_sel_onehot,

    input  logic       [lsq_depth-1:0]   wr_en,
    input  lsq_entry_t [lsq_depth-1:0]   wr_data,

    output lsq_entry_t [lsq_depth-1:0]   entry_douts,
    output logic       [lsq_depth-1:0]   entry_valid,
    output logic                         full
);

    localparam int cnt_w = $clog2(lsq_depth + 1);

    lsq_entry_t [lsq_depth-1:0] entries_q;
    lsq_entry_t [lsq_depth-1:0] entries_d;
    lsq_entry_t [lsq_depth-1:0] upd;
    logic       [lsq_depth-1:0] shift_mask;
    logic       [cnt_w-1:0]     count_q;
    logic       [cnt_w-1:0]     enq_idx;
    logic                       deq;
    logic                       enq_ok;

    assign deq    = |deq_sel_onehot;
    assign enq_ok = enq_valid & ~full;
    assign full   = (count_q == cnt_w'(lsq_depth));

    // After a dequeue the first free slot is one lower.
    assign enq_idx = count_q - cnt_w'(deq);

    // Entries at and above the selected slot move down by one.
    always_comb begin
        shift_mask[0] = deq_sel_onehot[0];
        for (int i = 1; i < lsq_depth; i++) begin
            shift_mask[i] = shift_mask[i-1] | deq_sel_onehot[i];
        end
    end

    always_comb begin
        for (int i = 0; i < lsq_depth; i++) begin
            upd[i] = wr_en[i] ? wr_data[i] : entries_q[i];
        end

        for (int i = 0; i < lsq_depth - 1; i++) begin
            entries_d[i] = shift_mask[i] ? upd[i+1] : upd[i];
        end
        entries_d[lsq_depth-1] = upd[lsq_depth-1];

        for (int i = 0; i < lsq_depth; i++) begin
            if (enq_ok && (cnt_w'(i) == enq_idx)) begin
                entries_d[i] = enq_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        entries_q <= entries_d;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + cnt_w'(enq_ok) - cnt_w'(deq);
        end
    end

    always_comb begin
        for (int i = 0; i < lsq_depth; i++) begin
            entry_valid[i] = (cnt_w'(i) < count_q);
        end
    end

    assign entry_douts = entries_q;

endmodule

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top
    import core_pkg::*, lsu_pkg::*;
#(
    parameter int lsq_depth = 8,
    parameter int stb_depth = 4
) (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    disp_valid,
    input  mem_op_e disp_op,
    input  rob_id_t disp_rob_id,
    input  logic    disp_base_ready,
    input  rob_id_t disp_base_tag,
    input  word_t   disp_base,
    input  offset_t disp_offset,
    input  logic    disp_data_ready,
    input  rob_id_t disp_data_tag,
    input  word_t   disp_st_data,

    input  logic    cdb_valid,
    input  rob_id_t cdb_rob_id,
    input  word_t   cdb_data,

    input  logic    st_commit,

    output logic    lsq_full,
    output logic    mem_rd_valid,
    output word_t   mem_rd_addr,
    output rob_id_t mem_rd_rob_id,
    output logic    mem_wr_valid,
    output word_t   mem_wr_addr,
    output word_t   mem_wr_data
);

    logic  st_hold;
    logic  st_wr_valid;
    word_t st_wr_addr;
    word_t st_wr_data;

    lsu_issue_if issue_bus ();

    load_store_issue #(
        .lsq_depth(lsq_depth)
    ) u_issue (
        .clk(clk),
        .rst_n(rst_n),
        .disp_valid(disp_valid),
        .disp_op(disp_op),
        .disp_rob_id(disp_rob_id),
        .disp_base_ready(disp_base_ready),
        .disp_base_tag(disp_base_tag),
        .disp_base(disp_base),
        .disp_offset(disp_offset),
        .disp_data_ready(disp_data_ready),
        .disp_data_tag(disp_data_tag),
        .disp_st_data(disp_st_data),
        .cdb_valid(cdb_valid),
        .cdb_rob_id(cdb_rob_id),
        .cdb_data(cdb_data),
        .st_hold(st_hold),
        .issue(issue_bus.src),
        .lsq_full(lsq_full)
    );

    address_gen u_agen (
        .clk(clk),
        .rst_n(rst_n),
        .issue(issue_bus.dst),
        .mem_rd_valid(mem_rd_valid),
        .mem_rd_addr(mem_rd_addr),
        .mem_rd_rob_id(mem_rd_rob_id),
        .st_wr_valid(st_wr_valid),
        .st_wr_addr(st_wr_addr),
        .st_wr_data(st_wr_data)
    );

    store_buffer #(
        .stb_depth(stb_depth)
    ) u_stb (
        .clk(clk),
        .rst_n(rst_n),
        .st_wr_valid(st_wr_valid),
        .st_wr_addr(st_wr_addr),
        .st_wr_data(st_wr_data),
        .st_commit(st_commit),
        .mem_wr_valid(mem_wr_valid),
        .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data),
        .st_hold(st_hold)
    );

endmodule

// ==== rtl/store_buffer.sv ====
`timescale 1ns/1ns

module store_buffer
    import core_pkg::*;
#(
    parameter int stb_depth = 4
) (
    input  logic  clk,
    input  logic  rst_n,

    input  logic  st_wr_valid,
    input  word_t st_wr_addr,
    input  word_t st_wr_data,

    input  logic  st_commit,

    output logic  mem_wr_valid,
    output word_t mem_wr_addr,
    output word_t mem_wr_data,

    output logic  st_hold
);

    localparam int ptr_w = (stb_depth > 1) ? $clog2(stb_depth) : 1;
    localparam int cnt_w = $clog2(stb_depth + 1);

    word_t            addr_mem [stb_depth];
    word_t            data_mem [stb_depth];
    logic [ptr_w-1:0] head_q;
    logic [ptr_w-1:0] tail_q;
    logic [cnt_w-1:0] count_q;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(stb_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (st_wr_valid) begin
            addr_mem[tail_q] <= st_wr_addr;
            data_mem[tail_q] <= st_wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            mem_wr_valid <= 1'b0;
        end else begin
            if (st_wr_valid) begin
                tail_q <= next_ptr(tail_q);
            end
            if (st_commit) begin
                head_q <= next_ptr(head_q);
            end
            count_q      <= count_q + cnt_w'(st_wr_valid) - cnt_w'(st_commit);
            mem_wr_valid <= st_commit;
        end
    end

    always_ff @(posedge clk) begin
        if (st_commit) begin
            mem_wr_addr <= addr_mem[head_q];
            mem_wr_data <= data_mem[head_q];
        end
    end

    // Two stores can still be in flight behind a new selection.
    assign st_hold = (count_q >= cnt_w'(stb_depth - 2));

endmodule

// ==== src.f ====
common/core_pkg.sv
common/lsu_pkg.sv
common/lsu_issue_if.sv
rtl/load_store_issue/shift_queue.sv
rtl/load_store_issue/load_store_issue.sv
rtl/address_gen.sv
rtl/store_buffer.sv
rtl/lsu_top.sv
tb/tb_lsu.sv

// ==== tb/tb_lsu.sv ====
`timescale 1ns/1ns

module tb_lsu
    import core_pkg::*, lsu_pkg::*;
();

    localparam int lsq_depth   = 8;
    localparam int stb_depth   = 4;
    localparam int n_ops       = 400;
    localparam int rand_ops    = 280;
    localparam int hold_cycles = 120;
    localparam int drain_limit = 2000;
    localparam int pool_max    = 8;
    localparam longint watchdog_ns = longint'(n_ops) * 40 * 100;

    typedef struct packed {
        rob_id_t rob_id;
        word_t   addr;
    } load_exp_t;

    typedef struct packed {
        rob_id_t rob_id;
        word_t   addr;
        word_t   data;
    } store_exp_t;

    logic    clk;
    logic    rst_n;
    logic    disp_valid;
    mem_op_e disp_op;
    rob_id_t disp_rob_id;
    logic    disp_base_ready;
    rob_id_t disp_base_tag;
    word_t   disp_base;
    offset_t disp_offset;
    logic    disp_data_ready;
    rob_id_t disp_data_tag;
    word_t   disp_st_data;
    logic    cdb_valid;
    rob_id_t cdb_rob_id;
    word_t   cdb_data;
    logic    st_commit;
    logic    lsq_full;
    logic    mem_rd_valid;
    word_t   mem_rd_addr;
    rob_id_t mem_rd_rob_id;
    logic    mem_wr_valid;
    word_t   mem_wr_addr;
    word_t   mem_wr_data;

    logic [31:0] lfsr;
    logic        busy [32];
    word_t       tag_val [32];
    rob_id_t     pool [$];
    load_exp_t   exp_loads [rob_id_t];
    store_exp_t  store_q [$];
    rob_id_t     next_rob;
    int          stb_model;
    logic        commit_last;
    int          value_errs;
    int          other_errs;
    int          ops_sent;
    int          loads_seen;
    int          stores_seen;

    lsu_top #(
        .lsq_depth(lsq_depth),
        .stb_depth(stb_depth)
    ) dut (.*);

    always #50 clk = ~clk;

    // Galois LFSR stepped once per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Two's complement value of the 12-bit immediate.
    function automatic word_t sign_ext(input offset_t off);
        int val;
        val = int'(off);
        if (off[offset_w-1]) begin
            val = val - (1 << offset_w);
        end
        return word_t'(val);
    endfunction

    function automatic logic take_tag(output rob_id_t tag);
        if (busy[next_rob]) begin
            return 1'b0;
        end
        tag            = next_rob;
        busy[next_rob] = 1'b1;
        next_rob       = next_rob + 1'b1;
        return 1'b1;
    endfunction

    // Either share a pending producer or open a new one with its future value.
    function automatic logic pick_producer(output rob_id_t tag);
        if ((pool.size() > 0) && (rand_bits(1) || (pool.size() >= pool_max))) begin
            tag = pool[rand_bits(8) % pool.size()];
            return 1'b1;
        end
        if ((pool.size() < pool_max) && take_tag(tag)) begin
            tag_val[tag] = rand_bits(32);
            pool.push_back(tag);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_load(input rob_id_t got_id, input rob_id_t exp_id,
                              input word_t got_addr, input word_t exp_addr);
        if ((got_id !== exp_id) || (got_addr !== exp_addr)) begin
            $display("ERROR %0t: load rob_id %0d addr %h, expected rob_id %0d addr %h",
                     $time, got_id, got_addr, exp_id, exp_addr);
            value_errs++;
        end
    endtask

    task automatic check_store(input word_t got_addr, input word_t exp_addr,
                               input word_t got_data, input word_t exp_data);
        if ((got_addr !== exp_addr) || (got_data !== exp_data)) begin
            $display("ERROR %0t: store addr %h data %h, expected addr %h data %h",
                     $time, got_addr, got_data, exp_addr, exp_data);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_outputs();
        store_exp_t st;
        if (mem_rd_valid) begin
            if (exp_loads.exists(mem_rd_rob_id)) begin
                check_load(mem_rd_rob_id, exp_loads[mem_rd_rob_id].rob_id,
                           mem_rd_addr, exp_loads[mem_rd_rob_id].addr);
                exp_loads.delete(mem_rd_rob_id);
                busy[mem_rd_rob_id] = 1'b0;
                loads_seen++;
            end else begin
                $display("Load with rob_id %0d at %0t was never dispatched or issued twice",
                         mem_rd_rob_id, $time);
                other_errs++;
            end
        end
        check_flag("mem_wr_valid", mem_wr_valid, commit_last);
        if (mem_wr_valid) begin
            if (store_q.size() == 0) begin
                $display("A store was written at %0t with none outstanding", $time);
                other_errs++;
            end else begin
                st = store_q.pop_front();
                check_store(mem_wr_addr, st.addr, mem_wr_data, st.data);
                busy[st.rob_id] = 1'b0;
                stores_seen++;
            end
        end
    endtask

    // Check outputs on the falling edge, then drive the next inputs.
    task automatic step(input logic en_disp, input logic en_cdb, input logic en_commit,
                        input int st_odds, input logic no_ready);
        rob_id_t    id;
        rob_id_t    btag;
        rob_id_t    dtag;
        word_t      bval;
        word_t      dval;
        logic       bready;
        logic       dready;
        logic       commit_now;
        int         idx;
        load_exp_t  ld;
        store_exp_t st;

        @(negedge clk);
        check_outputs();
        disp_valid = 1'b0;
        cdb_valid  = 1'b0;

        // Only stores already written into the buffer may be committed.
        commit_now = en_commit && (stb_model > 0) && rand_bits(1);
        if (commit_now) begin
            stb_model--;
        end
        if (dut.u_agen.st_wr_valid) begin
            stb_model++;
        end
        st_commit   = commit_now;
        commit_last = commit_now;

        btag   = '0;
        bready = 1'b1;
        if (en_disp && !lsq_full && rand_bits(1) && take_tag(id)) begin
            disp_op      = (rand_bits(2) < st_odds) ? op_store : op_load;
            disp_rob_id  = id;
            disp_base    = rand_bits(32);
            disp_st_data = rand_bits(32);
            disp_offset  = offset_t'(rand_bits(offset_w));
            btag   = rob_id_t'(rand_bits(rob_id_w));
            dtag   = rob_id_t'(rand_bits(rob_id_w));
            bready = no_ready ? 1'b0 : rand_bits(1);
            dready = (disp_op == op_load) || (no_ready ? 1'b0 : rand_bits(1));
            if (!bready && !pick_producer(btag)) begin
                bready = 1'b1;
            end
            if (!dready && !pick_producer(dtag)) begin
                dready = 1'b1;
            end
            bval = bready ? disp_base : tag_val[btag];
            dval = dready ? disp_st_data : tag_val[dtag];
            disp_valid      = 1'b1;
            disp_base_ready = bready;
            disp_base_tag   = btag;
            disp_data_ready = dready;
            disp_data_tag   = dtag;
            if (disp_op == op_store) begin
                st.rob_id = id;
                st.addr   = bval + sign_ext(disp_offset);
                st.data   = dval;
                store_q.push_back(st);
            end else begin
                ld.rob_id     = id;
                ld.addr       = bval + sign_ext(disp_offset);
                exp_loads[id] = ld;
            end
            ops_sent++;
        end

        if (en_cdb && (pool.size() > 0) && (rand_bits(2) != 0)) begin
            idx = rand_bits(8) % pool.size();
            // Sometimes hit the tag the new op waits on in its own dispatch cycle.
            if (disp_valid && !bready && rand_bits(1)) begin
                for (int k = 0; k < pool.size(); k++) begin
                    if (pool[k] == btag) begin
                        idx = k;
                    end
                end
            end
            cdb_valid       = 1'b1;
            cdb_rob_id      = pool[idx];
            cdb_data        = tag_val[pool[idx]];
            busy[pool[idx]] = 1'b0;
            pool.delete(idx);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (((pool.size() > 0) || (exp_loads.size() > 0) || (store_q.size() > 0))
               && (n < drain_limit)) begin
            step(1'b0, 1'b1, 1'b1, 2, 1'b0);
            n++;
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Errors found");
        $finish;
    end

    initial begin
        int hold_loads;
        int hold_stores;

        lfsr            = 32'heabb_374a;
        clk             = 1'b0;
        rst_n           = 1'b0;
        disp_valid      = 1'b0;
        disp_op         = op_load;
        disp_rob_id     = '0;
        disp_base_ready = 1'b0;
        disp_base_tag   = '0;
        disp_base       = '0;
        disp_offset     = '0;
        disp_data_ready = 1'b0;
        disp_data_tag   = '0;
        disp_st_data    = '0;
        cdb_valid       = 1'b0;
        cdb_rob_id      = '0;
        cdb_data        = '0;
        st_commit       = 1'b0;
        for (int i = 0; i < 32; i++) begin
            busy[i]    = 1'b0;
            tag_val[i] = '0;
        end
        next_rob    = '0;
        stb_model   = 0;
        commit_last = 1'b0;
        value_errs  = 0;
        other_errs  = 0;
        ops_sent    = 0;
        loads_seen  = 0;
        stores_seen = 0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        check_flag("mem_rd_valid after reset", mem_rd_valid, 1'b0);
        check_flag("mem_wr_valid after reset", mem_wr_valid, 1'b0);
        check_flag("lsq_full after reset", lsq_full, 1'b0);
        rst_n = 1'b1;

        // Fill the queue with ops that all wait on producers.
        while (ops_sent < lsq_depth) begin
            step(1'b1, 1'b0, 1'b0, 2, 1'b1);
            check_flag("lsq_full while filling", lsq_full, 1'b0);
        end
        step(1'b0, 1'b0, 1'b0, 2, 1'b1);
        check_flag("lsq_full after fill", lsq_full, 1'b1);
        drain();
        check_flag("lsq_full after drain", lsq_full, 1'b0);

        while (ops_sent < lsq_depth + rand_ops) begin
            step(1'b1, 1'b1, 1'b1, 2, 1'b0);
        end

        // Loads should keep flowing while commits are withheld.
        step(1'b1, 1'b1, 1'b0, 1, 1'b0);
        hold_loads  = loads_seen;
        hold_stores = stores_seen;
        repeat (hold_cycles) begin
            step(1'b1, 1'b1, 1'b0, 1, 1'b0);
        end
        if (loads_seen == hold_loads) begin
            $display("No load reached the read port while commits were withheld");
            other_errs++;
        end
        if (stores_seen != hold_stores) begin
            $display("A store reached the write port while commits were withheld");
            other_errs++;
        end
        if (store_q.size() == 0) begin
            $display("No store was left waiting while commits were withheld");
            other_errs++;
        end

        drain();
        step(1'b0, 1'b0, 1'b0, 2, 1'b0);
        if (exp_loads.size() > 0) begin
            $display("%0d loads never appeared on the read port", exp_loads.size());
            other_errs++;
        end
        if (store_q.size() > 0) begin
            $display("%0d stores never appeared on the write port", store_q.size());
            other_errs++;
        end

        $display("Done: %0d ops, %0d loads, %0d stores, %0d value errors, %0d other errors",
                 ops_sent, loads_seen, stores_seen, value_errs, other_errs);
        if ((value_errs == 0) && (other_errs == 0)) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
